// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dma_controller_tb
RTL_TOP   ?= dma_controller
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/dma_bus_pkg.sv ====
`include "dma_macros.svh"

package dma_bus_pkg;

    // Byte address on the system bus
    typedef logic [`DMA_BUS_AW-1:0] bus_addr_t;

    // Address step for one 32-bit word
    localparam bus_addr_t BUS_WORD_BYTES = 4;

    // Transfer engine states
    typedef enum logic [2:0] {
        IDLE,
        REQUEST,
        BEGIN,
        RECEIVE,
        RELEASE
    } engine_state_t;

endpackage

// ==== design/dma_cfg_if.sv ====
interface dma_cfg_if
    import dma_ci_pkg::*;
    import dma_bus_pkg::*;
();

    // Transfer setup held by the register block
    bus_addr_t   bus_start_address;
    mem_addr_t   memory_start_address;
    block_size_t block_size;
    burst_size_t burst_size;
    // One-cycle start request
    logic        start;

    // Engine status
    logic        busy;
    logic        error;

    modport regs (
        output bus_start_address, memory_start_address, block_size, burst_size, start,
        input  busy, error
    );

    modport engine (
        input  bus_start_address, memory_start_address, block_size, burst_size, start,
        output busy, error
    );

endinterface

// ==== design/dma_ci_pkg.sv ====
`include "dma_macros.svh"

package dma_ci_pkg;

    typedef logic [`DMA_WORD_W-1:0]   word_t;
    typedef logic [`DMA_MEM_AW-1:0]   mem_addr_t;
    typedef logic [`DMA_BLOCK_W-1:0]  block_size_t;
    typedef logic [`DMA_BURST_W-1:0]  burst_size_t;
    typedef logic [`DMA_STATUS_W-1:0] status_t;

    // Operation code in valueA[12:10]
    typedef enum logic [2:0] {
        OP_MEMORY      = 3'd0,
        OP_BUS_START   = 3'd1,
        OP_MEM_START   = 3'd2,
        OP_BLOCK_SIZE  = 3'd3,
        OP_BURST_SIZE  = 3'd4,
        OP_STATUS_CTRL = 3'd5
    } ci_op_t;

    // Field positions in valueA, valueB and the status word
    localparam int CI_OP_LSB    = 10;
    localparam int CI_RW_BIT    = 9;
    localparam int CI_START_BIT = 0;
    localparam int STATUS_BUSY  = 0;
    localparam int STATUS_ERROR = 1;

endpackage

// ==== design/dma_ci_regs.sv ====
`include "dma_macros.svh"

module dma_ci_regs
    import dma_ci_pkg::*;
    import dma_bus_pkg::*;
#(
    parameter logic [7:0] custom_id = `DMA_CUSTOM_ID
) (
    input  logic       clk,
    input  logic       rst,

    // Custom instruction port
    input  logic       ci_start,
    input  logic [7:0] ci_n,
    input  word_t      value_a,
    input  word_t      value_b,
    output logic       ci_done,
    output word_t      result,

    // Transfer configuration and status
    dma_cfg_if.regs    cfg,

    // Processor port of local memory
    output mem_addr_t  mem_addr,
    output word_t      mem_wdata,
    output logic       mem_we,
    input  word_t      mem_rdata
);

    logic    sel;
    logic    wr;
    ci_op_t  op;
    status_t status;
    word_t   reg_rdata_d;
    word_t   reg_rdata;
    // Pending read sources for the completion cycle
    logic    rd_mem;
    logic    rd_reg;

    // Instruction accepted only for our own number
    assign sel = ci_start && (ci_n == custom_id);
    assign wr  = value_a[CI_RW_BIT];
    assign op  = ci_op_t'(value_a[CI_OP_LSB +: 3]);

    // Memory word address is valueA[8:0]
    assign mem_addr  = mem_addr_t'(value_a);
    assign mem_wdata = value_b;
    assign mem_we    = sel && wr && (op == OP_MEMORY);

    // Busy in bit 0, error in bit 1
    always_comb begin
        status               = '0;
        status[STATUS_BUSY]  = cfg.busy;
        status[STATUS_ERROR] = cfg.error;
    end

    // Register read select, zero-extended to a full word
    always_comb begin
        case (op)
            OP_BUS_START:   reg_rdata_d = word_t'(cfg.bus_start_address);
            OP_MEM_START:   reg_rdata_d = word_t'(cfg.memory_start_address);
            OP_BLOCK_SIZE:  reg_rdata_d = word_t'(cfg.block_size);
            OP_BURST_SIZE:  reg_rdata_d = word_t'(cfg.burst_size);
            OP_STATUS_CTRL: reg_rdata_d = word_t'(status);
            // Memory comes from the RAM, codes 6 and 7 read as zero
            default:        reg_rdata_d = '0;
        endcase
    end

    // Completion flags, start pulse and configuration writes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ci_done                  <= 1'b0;
            rd_mem                   <= 1'b0;
            rd_reg                   <= 1'b0;
            cfg.start                <= 1'b0;
            cfg.bus_start_address    <= '0;
            cfg.memory_start_address <= '0;
            cfg.block_size           <= '0;
            cfg.burst_size           <= '0;
        end else begin
            ci_done   <= sel;
            rd_mem    <= sel && !wr && (op == OP_MEMORY);
            rd_reg    <= sel && !wr && (op != OP_MEMORY);
            // Control write with bit 0 set requests a transfer
            cfg.start <= sel && wr && (op == OP_STATUS_CTRL) && value_b[CI_START_BIT];
            if (sel && wr) begin
                case (op)
                    OP_BUS_START:  cfg.bus_start_address    <= bus_addr_t'(value_b);
                    OP_MEM_START:  cfg.memory_start_address <= mem_addr_t'(value_b);
                    OP_BLOCK_SIZE: cfg.block_size           <= block_size_t'(value_b);
                    OP_BURST_SIZE: cfg.burst_size           <= burst_size_t'(value_b);
                    default: ;
                endcase
            end
        end
    end

    // Register read data sampled with the request
    always_ff @(posedge clk) begin
        if (sel) begin
            reg_rdata <= reg_rdata_d;
        end
    end

    // Result only valid alongside ci_done
    always_comb begin
        if (ci_done && rd_mem) begin
            result = mem_rdata;
        end else if (ci_done && rd_reg) begin
            result = reg_rdata;
        end else begin
            result = '0;
        end
    end

endmodule

// ==== design/dma_controller.sv ====
`include "dma_macros.svh"

module dma_controller #(
    parameter logic [7:0] custom_id = `DMA_CUSTOM_ID
) (
    input  logic                    clk,
    input  logic                    rst,

    // Custom instruction port
    input  logic                    ci_start,
    input  logic [7:0]              ci_n,
    input  logic [`DMA_WORD_W-1:0]  value_a,
    input  logic [`DMA_WORD_W-1:0]  value_b,
    output logic                    ci_done,
    output logic [`DMA_WORD_W-1:0]  result,

    // System bus
    output logic                    bus_request,
    input  logic                    bus_grant,
    input  logic                    busy_in,
    output logic                    bus_begin_transaction,
    output logic [`DMA_BUS_AW-1:0]  bus_address,
    output logic [`DMA_BURST_W-1:0] bus_burst_size,
    input  logic                    data_valid,
    input  logic [`DMA_WORD_W-1:0]  bus_data,
    input  logic                    bus_error
);

    // Processor side of local memory
    logic [`DMA_MEM_AW-1:0] mem_addr;
    logic [`DMA_WORD_W-1:0] mem_wdata;
    logic                   mem_we;
    logic [`DMA_WORD_W-1:0] mem_rdata;

    // Engine side of local memory
    logic [`DMA_MEM_AW-1:0] eng_addr;
    logic [`DMA_WORD_W-1:0] eng_wdata;
    logic                   eng_we;

    // Registers to engine
    dma_cfg_if cfg_bus ();

    dma_ci_regs #(
        .custom_id (custom_id)
    ) u_regs (
        .clk       (clk),
        .rst       (rst),
        .ci_start  (ci_start),
        .ci_n      (ci_n),
        .value_a   (value_a),
        .value_b   (value_b),
        .ci_done   (ci_done),
        .result    (result),
        .cfg       (cfg_bus.regs),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata)
    );

    dma_local_mem u_mem (
        .clk       (clk),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_rdata (mem_rdata),
        .eng_addr  (eng_addr),
        .eng_wdata (eng_wdata),
        .eng_we    (eng_we)
    );

    dma_transfer_engine u_engine (
        .clk                   (clk),
        .rst                   (rst),
        .cfg                   (cfg_bus.engine),
        .bus_request           (bus_request),
        .bus_grant             (bus_grant),
        .busy_in               (busy_in),
        .bus_begin_transaction (bus_begin_transaction),
        .bus_address           (bus_address),
        .bus_burst_size        (bus_burst_size),
        .data_valid            (data_valid),
        .bus_data              (bus_data),
        .bus_error             (bus_error),
        .eng_addr              (eng_addr),
        .eng_wdata             (eng_wdata),
        .eng_we                (eng_we)
    );

endmodule

// ==== design/dma_local_mem.sv ====
`include "dma_macros.svh"

module dma_local_mem (
    input  logic                   clk,

    // Processor port, read and write
    input  logic [`DMA_MEM_AW-1:0] mem_addr,
    input  logic [`DMA_WORD_W-1:0] mem_wdata,
    input  logic                   mem_we,
    output logic [`DMA_WORD_W-1:0] mem_rdata,

    // Engine port, write only
    input  logic [`DMA_MEM_AW-1:0] eng_addr,
    input  logic [`DMA_WORD_W-1:0] eng_wdata,
    input  logic                   eng_we
);

    logic [`DMA_WORD_W-1:0] ram [`DMA_MEM_DEPTH];
    logic                   collide;

    // Both ports writing one word
    assign collide = eng_we && (eng_addr == mem_addr);

    always_ff @(posedge clk) begin
        // Processor write dropped when the engine hits the same word
        if (mem_we && !collide) begin
            ram[mem_addr] <= mem_wdata;
        end
        if (eng_we) begin
            ram[eng_addr] <= eng_wdata;
        end
        // Synchronous read, old data on a same-cycle write
        mem_rdata <= ram[mem_addr];
    end

endmodule

// ==== design/dma_macros.svh ====
`ifndef DMA_MACROS_SVH
`define DMA_MACROS_SVH

// Custom instruction number the controller answers to by default
`define DMA_CUSTOM_ID 8'h00

// Local memory geometry
`define DMA_MEM_DEPTH 512
`define DMA_MEM_AW    9

// Processor data word and system bus address
`define DMA_WORD_W    32
`define DMA_BUS_AW    32

// Transfer register widths
`define DMA_BLOCK_W   10
`define DMA_BURST_W   8
`define DMA_STATUS_W  2

`endif

// ==== design/dma_transfer_engine.sv ====
module dma_transfer_engine
    import dma_ci_pkg::*;
    import dma_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Configuration, start and status
    dma_cfg_if.engine   cfg,

    // System bus master side
    output logic        bus_request,
    input  logic        bus_grant,
    input  logic        busy_in,
    output logic        bus_begin_transaction,
    output bus_addr_t   bus_address,
    output burst_size_t bus_burst_size,
    input  logic        data_valid,
    input  word_t       bus_data,
    input  logic        bus_error,

    // Write port into local memory
    output mem_addr_t   eng_addr,
    output word_t       eng_wdata,
    output logic        eng_we
);

    engine_state_t state;

    // Running transfer, latched at start
    bus_addr_t   cur_addr;
    mem_addr_t   mem_ptr;
    block_size_t words_left;
    burst_size_t burst_cfg;
    // Words still due in the current burst
    burst_size_t burst_left;

    burst_size_t burst_eff;
    burst_size_t burst_len;
    logic        begin_ok;
    logic        take_word;
    logic        last_in_burst;
    logic        last_in_block;

    // Burst size zero behaves as one
    assign burst_eff = (burst_cfg == '0) ? burst_size_t'(1) : burst_cfg;

    // Next burst is the smaller of burst size and words left
    assign burst_len = (words_left < block_size_t'(burst_eff)) ?
                       burst_size_t'(words_left) : burst_eff;

    // Start only on a free, granted bus
    assign begin_ok  = (state == BEGIN) && bus_grant && !busy_in && !bus_error;
    assign take_word = (state == RECEIVE) && data_valid && !bus_error;

    assign last_in_burst = (burst_left == burst_size_t'(1));
    assign last_in_block = (words_left == block_size_t'(1));

    // Request held from REQUEST through the end of a burst
    assign bus_request = (state == REQUEST) || (state == BEGIN) || (state == RECEIVE);

    assign bus_begin_transaction = begin_ok;
    assign bus_address           = cur_addr;
    assign bus_burst_size        = burst_len;

    // Received words go straight to memory
    assign eng_addr  = mem_ptr;
    assign eng_wdata = bus_data;
    assign eng_we    = take_word;

    assign cfg.busy = (state != IDLE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            cur_addr   <= '0;
            mem_ptr    <= '0;
            words_left <= '0;
            burst_cfg  <= '0;
            burst_left <= '0;
            cfg.error  <= 1'b0;
        end else if ((state != IDLE) && bus_error) begin
            // Abort on bus error from any active state
            state     <= IDLE;
            cfg.error <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    // Empty blocks never start
                    if (cfg.start && (cfg.block_size != '0)) begin
                        cur_addr   <= cfg.bus_start_address;
                        mem_ptr    <= cfg.memory_start_address;
                        words_left <= cfg.block_size;
                        burst_cfg  <= cfg.burst_size;
                        cfg.error  <= 1'b0;
                        state      <= REQUEST;
                    end
                end
                REQUEST: begin
                    if (bus_grant) begin
                        state <= BEGIN;
                    end
                end
                BEGIN: begin
                    // Wait here while another master still holds the bus
                    if (begin_ok) begin
                        burst_left <= burst_len;
                        state      <= RECEIVE;
                    end else if (!bus_grant) begin
                        state <= REQUEST;
                    end
                end
                RECEIVE: begin
                    if (take_word) begin
                        // Memory pointer wraps at 512 on its own width
                        mem_ptr    <= mem_ptr + mem_addr_t'(1);
                        cur_addr   <= cur_addr + BUS_WORD_BYTES;
                        words_left <= words_left - block_size_t'(1);
                        burst_left <= burst_left - burst_size_t'(1);
                        if (last_in_burst) begin
                            state <= last_in_block ? IDLE : RELEASE;
                        end
                    end
                end
                RELEASE: begin
                    // Request low for this single cycle
                    state <= REQUEST;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

// ==== list.f ====
+incdir+design
design/dma_ci_pkg.sv
design/dma_bus_pkg.sv
design/dma_cfg_if.sv
design/dma_ci_regs.sv
design/dma_local_mem.sv
design/dma_transfer_engine.sv
design/dma_controller.sv
tb/dma_bus_model.sv
tb/dma_controller_tb.sv

// ==== tb/dma_bus_model.sv ====
module dma_bus_model (
    input  logic        clk,
    input  logic        rst,
    input  logic        bus_request,
    input  logic        bus_begin_transaction,
    input  logic [31:0] bus_address,
    input  logic [7:0]  bus_burst_size,
    // Error level commanded by the testbench
    input  logic        error_cmd,
    output logic        bus_grant,
    output logic        busy_in,
    output logic        data_valid,
    output logic [31:0] bus_data,
    output logic        bus_error
);
    timeunit 1ns;
    timeprecision 100ps;

    // Record of begin pulses
    int          begin_count;
    logic [31:0] last_address;
    logic [7:0]  last_size;

    logic [31:0] next_addr;
    int          words_due;
    int          grant_wait;
    logic        req_s;
    logic        begin_s;
    logic        err_s;
    logic [31:0] addr_s;
    logic [7:0]  size_s;

    assign bus_error = error_cmd;

    initial begin
        bus_grant    = 1'b0;
        busy_in      = 1'b0;
        data_valid   = 1'b0;
        bus_data     = '0;
        begin_count  = 0;
        last_address = '0;
        last_size    = '0;
        next_addr    = '0;
        words_due    = 0;
        grant_wait   = 0;
        forever begin
            // Master outputs are stable at the falling edge
            @(negedge clk);
            req_s   = bus_request;
            begin_s = bus_begin_transaction;
            err_s   = error_cmd;
            addr_s  = bus_address;
            size_s  = bus_burst_size;
            @(posedge clk);
            #1;
            // Grant follows a request after 0 to 3 cycles
            if (rst || !req_s || err_s) begin
                bus_grant  = 1'b0;
                grant_wait = $urandom % 4;
                words_due  = 0;
            end else if (!bus_grant) begin
                if (grant_wait == 0) begin
                    bus_grant = 1'b1;
                end else begin
                    grant_wait--;
                end
            end
            if (begin_s) begin
                begin_count++;
                last_address = addr_s;
                last_size    = size_s;
                next_addr    = addr_s;
                words_due    = size_s;
            end
            // Another master shows up now and then between bursts
            busy_in = (words_due == 0) && ($urandom % 6 == 0);
            // One word per valid cycle, random gaps
            if (words_due > 0 && ($urandom % 4) != 0) begin
                data_valid = 1'b1;
                bus_data   = next_addr ^ 32'hA5A5_0000;
                next_addr  = next_addr + 32'd4;
                words_due--;
            end else begin
                data_valid = 1'b0;
            end
        end
    end

endmodule

// ==== tb/dma_controller_tb.sv ====
`include "dma_macros.svh"

module dma_controller_tb
    import dma_ci_pkg::*;
    import dma_bus_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [7:0] CI_ID = `DMA_CUSTOM_ID;
    // Words moved by all transfers and a generous bound per word
    localparam int TOTAL_WORDS  = 42;
    localparam int CYCLES_WORD  = 30;
    localparam int WATCHDOG_NS  = (TOTAL_WORDS * CYCLES_WORD + 3000) * 10;
    localparam int POLL_LIMIT   = 400;

    logic        clk;
    logic        rst;
    logic        ci_start;
    logic [7:0]  ci_n;
    word_t       value_a;
    word_t       value_b;
    logic        ci_done;
    word_t       result;
    logic        bus_request;
    logic        bus_grant;
    logic        busy_in;
    logic        bus_begin_transaction;
    bus_addr_t   bus_address;
    burst_size_t bus_burst_size;
    logic        data_valid;
    word_t       bus_data;
    logic        bus_error;
    logic        error_cmd;

    // Expected transfer and words seen on the bus
    string       test_name = "reset";
    bus_addr_t   exp_bus_start = '0;
    int          exp_block = 0;
    int          exp_burst = 0;
    int          word_count = 0;
    int          count_base = 0;
    logic        xfer_active = 1'b0;
    // Request seen low since the last begin pulse
    logic        req_low_seen = 1'b1;
    word_t       rd;

    dma_controller #(.custom_id(CI_ID)) UUT (
        .clk(clk), .rst(rst), .ci_start(ci_start), .ci_n(ci_n),
        .value_a(value_a), .value_b(value_b), .ci_done(ci_done), .result(result),
        .bus_request(bus_request), .bus_grant(bus_grant), .busy_in(busy_in),
        .bus_begin_transaction(bus_begin_transaction), .bus_address(bus_address),
        .bus_burst_size(bus_burst_size), .data_valid(data_valid), .bus_data(bus_data),
        .bus_error(bus_error)
    );

    dma_bus_model bus (
        .clk(clk), .rst(rst), .bus_request(bus_request),
        .bus_begin_transaction(bus_begin_transaction), .bus_address(bus_address),
        .bus_burst_size(bus_burst_size), .error_cmd(error_cmd), .bus_grant(bus_grant),
        .busy_in(busy_in), .data_valid(data_valid), .bus_data(bus_data),
        .bus_error(bus_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Words accepted by the engine
    always @(posedge clk) begin
        if (data_valid && !bus_error) begin
            word_count <= word_count + 1;
        end
    end

    // Cleared by a begin pulse and set again once request drops
    always @(posedge clk) begin
        if (bus_begin_transaction) begin
            req_low_seen <= 1'b0;
        end else if (!bus_request) begin
            req_low_seen <= 1'b1;
        end
    end

    task automatic report_mismatch(string what, word_t expected, word_t actual);
        $display("** Error [%s] %s: expected %0h, actual %0h", test_name, what, expected, actual);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic report_failure(string what);
        $display("[%s] failed: %s", test_name, what);
        $display("Some tests failed");
        $fatal(1);
    endtask

    // Smaller of burst size and words left where a zero burst means one
    function automatic int burst_expected(int burst, int left);
        int eff;
        eff = (burst == 0) ? 1 : burst;
        return (left < eff) ? left : eff;
    endfunction

    function automatic word_t pattern_at(bus_addr_t addr);
        return addr ^ 32'hA5A5_0000;
    endfunction

    a_done: assert property (@(posedge clk) disable iff (rst)
        (ci_start && ci_n == CI_ID) |=> ci_done)
        else report_failure("ci_done missing one cycle after ci_start");
    a_no_done: assert property (@(posedge clk) disable iff (rst)
        !(ci_start && ci_n == CI_ID) |=> !ci_done)
        else report_failure("ci_done without an accepted instruction");
    a_free_bus: assert property (@(posedge clk) disable iff (rst)
        bus_begin_transaction |-> (bus_grant && !busy_in))
        else report_failure("begin pulse while the bus was not free");
    a_size: assert property (@(posedge clk) disable iff (rst)
        bus_begin_transaction |->
            bus_burst_size == burst_expected(exp_burst, exp_block - (word_count - count_base)))
        else report_mismatch("burst size",
            burst_expected(exp_burst, exp_block - (word_count - count_base)), bus_burst_size);
    a_addr: assert property (@(posedge clk) disable iff (rst)
        bus_begin_transaction |-> bus_address == exp_bus_start + 4 * (word_count - count_base))
        else report_mismatch("burst address",
            exp_bus_start + 4 * (word_count - count_base), bus_address);
    // Request drops before every burst
    a_drop: assert property (@(posedge clk) disable iff (rst)
        bus_begin_transaction |-> req_low_seen)
        else report_failure("bus_request stayed high between bursts");
    // One low cycle of request between bursts
    a_release: assert property (@(posedge clk) disable iff (rst)
        ($fell(bus_request) && xfer_active && (word_count - count_base) < exp_block)
            |=> bus_request)
        else report_failure("bus_request low for more than one cycle between bursts");
    a_no_req: assert property (@(posedge clk) disable iff (rst)
        $rose(bus_request) |-> xfer_active)
        else report_failure("bus_request raised without a valid start");

    task automatic ci_issue(logic [7:0] id, ci_op_t op, logic wr, mem_addr_t addr,
                            word_t data, output word_t rdata);
        ci_n     = id;
        value_a  = {19'b0, op, wr, addr};
        value_b  = data;
        ci_start = 1'b1;
        @(posedge clk);
        #1;
        ci_start = 1'b0;
        rdata    = result;
    endtask

    task automatic ci_write(ci_op_t op, mem_addr_t addr, word_t data);
        word_t unused;
        ci_issue(CI_ID, op, 1'b1, addr, data, unused);
    endtask

    task automatic ci_read(ci_op_t op, mem_addr_t addr, output word_t data);
        ci_issue(CI_ID, op, 1'b0, addr, '0, data);
    endtask

    task automatic check_equal(string what, word_t expected, word_t actual);
        assert (actual === expected) else report_mismatch(what, expected, actual);
    endtask

    task automatic start_transfer(bus_addr_t bstart, mem_addr_t mstart, int block, int burst);
        ci_write(OP_BUS_START, '0, bstart);
        ci_write(OP_MEM_START, '0, word_t'(mstart));
        ci_write(OP_BLOCK_SIZE, '0, word_t'(block));
        ci_write(OP_BURST_SIZE, '0, word_t'(burst));
        exp_bus_start = bstart;
        exp_block     = block;
        exp_burst     = burst;
        count_base    = word_count;
        xfer_active   = 1'b1;
        ci_write(OP_STATUS_CTRL, '0, 32'd1);
    endtask

    // Poll status bit 0 until the engine is busy, then until it goes idle
    task automatic finish_transfer();
        word_t st;
        int    n;
        st = '0;
        // Busy appears one edge after the registered start pulse
        for (n = 0; n < POLL_LIMIT && !st[STATUS_BUSY]; n++) begin
            ci_read(OP_STATUS_CTRL, '0, st);
        end
        assert (st[STATUS_BUSY]) else report_failure("transfer never became busy");
        for (n = 0; n < POLL_LIMIT && st[STATUS_BUSY]; n++) begin
            ci_read(OP_STATUS_CTRL, '0, st);
        end
        assert (!st[STATUS_BUSY]) else report_failure("transfer never left busy");
        xfer_active = 1'b0;
        check_equal("word count", exp_block, word_count - count_base);
        check_equal("status after transfer", 32'd0, st);
    endtask

    task automatic wait_words(int n);
        int c;
        for (c = 0; c < POLL_LIMIT && (word_count - count_base) < n; c++) begin
            @(posedge clk);
            #1;
        end
        assert ((word_count - count_base) >= n) else report_failure("transfer stalled");
    endtask

    task automatic check_memory(bus_addr_t bstart, mem_addr_t mstart, int n);
        word_t d;
        for (int i = 0; i < n; i++) begin
            ci_read(OP_MEMORY, mstart + mem_addr_t'(i), d);
            check_equal("memory word", pattern_at(bstart + 4 * i), d);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_failure("watchdog expired, the run hung");
    end

    initial begin
        int base;
        void'($urandom(52));
        rst       = 1'b1;
        ci_start  = 1'b0;
        ci_n      = '0;
        value_a   = '0;
        value_b   = '0;
        error_cmd = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "reset and registers";
        assert (!bus_request && !ci_done) else report_failure("outputs active after reset");
        ci_read(OP_STATUS_CTRL, '0, rd);
        check_equal("status", 32'd0, rd);
        ci_write(OP_BUS_START, '0, 32'hDEAD_BEEF);
        ci_read(OP_BUS_START, '0, rd);
        check_equal("bus start", 32'hDEAD_BEEF, rd);
        ci_write(OP_MEM_START, '0, 32'hFFFF_FE5A);
        ci_read(OP_MEM_START, '0, rd);
        check_equal("memory start", 32'h0000_005A, rd);
        ci_write(OP_BLOCK_SIZE, '0, 32'h1234_5ABC);
        ci_read(OP_BLOCK_SIZE, '0, rd);
        check_equal("block size", 32'h0000_02BC, rd);
        ci_write(OP_BURST_SIZE, '0, 32'h0000_0F3C);
        ci_read(OP_BURST_SIZE, '0, rd);
        check_equal("burst size", 32'h0000_003C, rd);

        test_name = "local memory";
        ci_write(OP_MEMORY, 9'd3, 32'h1357_9BDF);
        ci_write(OP_MEMORY, 9'd511, 32'h0BAD_F00D);
        // Foreign instruction number leaves memory alone
        ci_issue(8'h5A, OP_MEMORY, 1'b1, 9'd3, 32'hFFFF_FFFF, rd);
        repeat (3) @(posedge clk);
        #1;
        ci_read(OP_MEMORY, 9'd3, rd);
        check_equal("memory 3", 32'h1357_9BDF, rd);
        ci_read(OP_MEMORY, 9'd511, rd);
        check_equal("memory 511", 32'h0BAD_F00D, rd);

        test_name = "wrapping transfer";
        base = bus.begin_count;
        start_transfer(32'h0000_1000, 9'd506, 10, 4);
        finish_transfer();
        check_equal("burst count", 32'd3, bus.begin_count - base);
        // Last burst carries words 8 and 9 of the block
        check_equal("last burst address", 32'h0000_1020, bus.last_address);
        check_equal("last burst size", 32'd2, word_t'(bus.last_size));
        check_memory(32'h0000_1000, 9'd506, 10);

        test_name = "bus error";
        start_transfer(32'h0000_4000, 9'd40, 12, 3);
        wait_words(5);
        xfer_active = 1'b0;
        error_cmd   = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        error_cmd = 1'b0;
        assert (!bus_request) else report_failure("bus_request still high after error");
        ci_read(OP_STATUS_CTRL, '0, rd);
        check_equal("status after error", 32'd2, rd);
        start_transfer(32'h0000_4000, 9'd40, 12, 3);
        finish_transfer();
        check_memory(32'h0000_4000, 9'd40, 12);

        test_name = "ignored starts";
        ci_write(OP_BLOCK_SIZE, '0, 32'd0);
        ci_write(OP_STATUS_CTRL, '0, 32'd1);
        repeat (20) @(posedge clk);
        #1;
        ci_read(OP_STATUS_CTRL, '0, rd);
        check_equal("status after empty start", 32'd0, rd);
        start_transfer(32'h0000_2000, 9'd100, 8, 0);
        wait_words(2);
        ci_write(OP_BLOCK_SIZE, '0, 32'd3);
        ci_write(OP_STATUS_CTRL, '0, 32'd1);
        finish_transfer();
        check_memory(32'h0000_2000, 9'd100, 8);

        $display("All tests passed");
        $finish;
    end

endmodule
